/* compile.f */
+incdir+hw
hw/video_pkg.sv
hw/video_cfg_regs.sv
hw/umuldiv.sv
hw/window_calc.sv
hw/sync_polarity.sv
hw/csync_gen.sv
hw/video_helper_top.sv
testbench/video_helper_assert.sv
testbench/tb_video_helper.sv

/* testbench/tb_video_helper.sv */
/*
 * Testbench of the video helper. Drives the Wishbone slave and the raw
 * syncs with seeded random stimulus and checks the DUT against a model.
 */
`timescale 1ns/10ps
`include "video_consts.svh"

module tb_video_helper;

	localparam int LINE_LEN  = 40;
	localparam int HS_LEN    = 4;
	localparam int FRAME_LEN = 12;
	localparam int VS_LINES  = 3;

	logic                  clk_sys;
	logic                  resetd;
	logic                  i_wb_cyc;
	logic                  i_wb_stb;
	logic                  i_wb_we;
	video_pkg::reg_addr_t  i_wb_adr;
	video_pkg::bus_data_t  i_wb_dat;
	video_pkg::bus_data_t  o_wb_dat;
	logic                  o_wb_ack;
	logic                  i_hs_raw;
	logic                  i_vs_raw;
	video_pkg::coord_t     o_hmin, o_hmax, o_vmin, o_vmax;
	logic                  o_hs, o_vs, o_csync;

	integer               seed;
	int                   errors, checks, tests_run, tests_failed, test_err0;
	video_pkg::bus_data_t rd_data;

	video_helper_top u_video_helper_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////
	// Compare and bookkeeping
	////////////////////////////////////////

	task automatic check_coord(input string what, input video_pkg::coord_t got,
			input video_pkg::coord_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_data(input string what, input video_pkg::bus_data_t got,
			input video_pkg::bus_data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic start_test();
		test_err0 = errors;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors != test_err0) begin
			tests_failed++;
			$display("Test %0d %s: FAIL, %0d errors", tests_run, name, errors - test_err0);
		end else begin
			$display("Test %0d %s: ok", tests_run, name);
		end
	endtask

	function automatic int rand_range(input int lo, input int span);
		return lo + int'($unsigned($random(seed)) % span);
	endfunction

	////////////////////////////////////////
	// Wishbone master
	////////////////////////////////////////

	task automatic wb_access(input logic we, input video_pkg::reg_addr_t adr,
			input video_pkg::bus_data_t dat, output video_pkg::bus_data_t rdat);
		int wait_cnt;
		wait_cnt = 0;
		@(posedge clk_sys);
		i_wb_cyc <= 1'b1;
		i_wb_stb <= 1'b1;
		i_wb_we  <= we;
		i_wb_adr <= adr;
		i_wb_dat <= dat;
		@(negedge clk_sys);
		while (!o_wb_ack && wait_cnt < 16) begin
			@(negedge clk_sys);
			wait_cnt++;
		end
		if (!o_wb_ack) begin
			errors++;
			$display("No Wishbone ack within 16 cycles at address %0d, time %0t", adr, $time);
		end
		rdat = o_wb_dat;
		@(posedge clk_sys);
		i_wb_cyc <= 1'b0;
		i_wb_stb <= 1'b0;
		i_wb_we  <= 1'b0;
	endtask

	task automatic wb_write(input video_pkg::reg_addr_t adr, input video_pkg::bus_data_t dat);
		video_pkg::bus_data_t unused;
		wb_access(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input video_pkg::reg_addr_t adr, output video_pkg::bus_data_t dat);
		wb_access(1'b0, adr, '0, dat);
	endtask

	// Bits each register keeps
	function automatic video_pkg::bus_data_t field_mask(input video_pkg::reg_addr_t adr);
		case (adr)
			`VID_ADDR_WIDTH, `VID_ADDR_HEIGHT, `VID_ADDR_HSET, `VID_ADDR_VSET: return 16'h0fff;
			`VID_ADDR_FREESCALE: return 16'h0001;
			`VID_ADDR_ARX, `VID_ADDR_ARY: return 16'h1fff;
			default: return 16'h0000;
		endcase
	endfunction

	////////////////////////////////////////
	// Window model
	////////////////////////////////////////

	function automatic void model_window(
		input  video_pkg::coord_t  w, h, hs, vs,
		input  logic               fs,
		input  video_pkg::aspect_t ax, ay,
		output video_pkg::coord_t  hmin, hmax, vmin, vmax
	);
		int wl, hl, wc, hc, vw, vh, axv, ayv;
		axv = ax[`VID_COORD_BITS-1:0];
		ayv = ay[`VID_COORD_BITS-1:0];
		wl  = (hs != 0 && hs < w) ? hs : w;
		hl  = (vs != 0 && vs < h) ? vs : h;
		if (fs || ax == 0 || ay == 0) begin
			wc = wl;
			hc = hl;
		end else if (ax[`VID_ASPECT_BITS-1] || ay[`VID_ASPECT_BITS-1]) begin
			wc = axv;
			hc = ayv;
		end else begin
			// Only the low 12 quotient bits survive
			wc = (hl * axv / ayv) % 4096;
			hc = (wl * ayv / axv) % 4096;
		end
		vw   = (wc > wl) ? wl : wc;
		vh   = (hc > hl) ? hl : hc;
		hmin = (w - vw) / 2;
		vmin = (h - vh) / 2;
		hmax = hmin + vw - 1;
		vmax = vmin + vh - 1;
	endfunction

	task automatic expect_window(input video_pkg::coord_t w, h, hs, vs, input logic fs,
			input video_pkg::aspect_t ax, ay);
		video_pkg::coord_t e_hmin, e_hmax, e_vmin, e_vmax;
		int wait_cnt;
		model_window(w, h, hs, vs, fs, ax, ay, e_hmin, e_hmax, e_vmin, e_vmax);
		wait_cnt = 0;
		@(negedge clk_sys);
		while ({o_hmin, o_hmax, o_vmin, o_vmax} !== {e_hmin, e_hmax, e_vmin, e_vmax}
				&& wait_cnt < 200) begin
			@(negedge clk_sys);
			wait_cnt++;
		end
		if ({o_hmin, o_hmax, o_vmin, o_vmax} !== {e_hmin, e_hmax, e_vmin, e_vmax}) begin
			$display("Window did not settle within 200 cycles at time %0t", $time);
		end
		check_coord("hmin", o_hmin, e_hmin);
		check_coord("hmax", o_hmax, e_hmax);
		check_coord("vmin", o_vmin, e_vmin);
		check_coord("vmax", o_vmax, e_vmax);
	endtask

	// Aspect cleared first, so every intermediate setting gives the full size
	task automatic apply_window(input video_pkg::coord_t w, h, hs, vs, input logic fs,
			input video_pkg::aspect_t ax, ay);
		wb_write(`VID_ADDR_ARX, '0);
		wb_write(`VID_ADDR_WIDTH, w);
		wb_write(`VID_ADDR_HEIGHT, h);
		wb_write(`VID_ADDR_HSET, hs);
		wb_write(`VID_ADDR_VSET, vs);
		wb_write(`VID_ADDR_FREESCALE, fs);
		wb_write(`VID_ADDR_ARY, ay);
		wb_write(`VID_ADDR_ARX, ax);
		expect_window(w, h, hs, vs, fs, ax, ay);
	endtask

	////////////////////////////////////////
	// Sync stimulus
	////////////////////////////////////////

	// Lines of LINE_LEN cycles, hsync at line start, vsync over the first lines
	task automatic run_sync(input logic active_low, input logic check_cs, input int cycles,
			input int settle);
		logic hs_p, vs_p, hs_h1, hs_h2, vs_h1, vs_h2, ohs_1, ohs_2, ovs_1;
		hs_h1 = 1'b0;
		hs_h2 = 1'b0;
		vs_h1 = 1'b0;
		vs_h2 = 1'b0;
		ohs_1 = 1'b0;
		ohs_2 = 1'b0;
		ovs_1 = 1'b0;
		for (int i = 0; i < cycles; i++) begin
			hs_p = (i % LINE_LEN) < HS_LEN;
			vs_p = ((i / LINE_LEN) % FRAME_LEN) < VS_LINES;
			@(posedge clk_sys);
			i_hs_raw <= hs_p ^ active_low;
			i_vs_raw <= vs_p ^ active_low;
			@(negedge clk_sys);
			if (i >= settle) begin
				if (check_cs) begin
					if (!ovs_1) begin
						check_bit("o_csync outside vsync", o_csync, ohs_1);
					end else if (ohs_1 && !ohs_2) begin
						check_bit("o_csync after hsync rise", o_csync, 1'b1);
					end
				end else begin
					check_bit("o_hs", o_hs, hs_h2);
					check_bit("o_vs", o_vs, vs_h2);
				end
			end
			hs_h2 = hs_h1;
			hs_h1 = hs_p;
			vs_h2 = vs_h1;
			vs_h1 = vs_p;
			ohs_2 = ohs_1;
			ohs_1 = o_hs;
			ovs_1 = o_vs;
		end
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		video_pkg::bus_data_t wdat, exp_dat;
		video_pkg::reg_addr_t adr;
		video_pkg::coord_t    w, h, hs, vs;
		video_pkg::aspect_t   ax, ay;
		logic                 fs;
		int                   mode;
		seed         = 7;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		resetd       = 1'b1;
		i_wb_cyc     = 1'b0;
		i_wb_stb     = 1'b0;
		i_wb_we      = 1'b0;
		i_wb_adr     = '0;
		i_wb_dat     = '0;
		i_hs_raw     = 1'b1;
		i_vs_raw     = 1'b1;
		repeat (2) @(posedge clk_sys);
		resetd <= 1'b0;

		start_test();
		for (int a = 0; a < 16; a++) begin
			adr = a;
			exp_dat = (adr == `VID_ADDR_WIDTH)  ? 16'(`VID_RST_WIDTH) :
			          (adr == `VID_ADDR_HEIGHT) ? 16'(`VID_RST_HEIGHT) : 16'h0000;
			wb_read(adr, rd_data);
			check_data("reset readback", rd_data, exp_dat);
		end
		expect_window(`VID_RST_WIDTH, `VID_RST_HEIGHT, '0, '0, 1'b0, '0, '0);
		finish_test("reset values");

		start_test();
		wb_write(`VID_ADDR_FREESCALE, 16'h0001);
		for (int n = 0; n < 40; n++) begin
			adr  = video_pkg::reg_addr_t'($random(seed));
			wdat = video_pkg::bus_data_t'($random(seed));
			// Freescale stays on so random sizes never empty the window
			if (adr == `VID_ADDR_FREESCALE) begin
				wdat[0] = 1'b1;
			end
			wb_write(adr, wdat);
			wb_read(adr, rd_data);
			check_data("readback", rd_data, wdat & field_mask(adr));
		end
		finish_test("register readback");

		start_test();
		for (int n = 0; n < 8; n++) begin
			w  = rand_range(1, 4095);
			h  = rand_range(1, 4095);
			hs = rand_range(0, 4096);
			vs = rand_range(0, 4096);
			apply_window(w, h, hs, vs, 1'b0, '0, '0);
		end
		finish_test("size limits");

		start_test();
		for (int n = 0; n < 12; n++) begin
			mode = rand_range(0, 3);
			w    = rand_range(64, 512);
			h    = rand_range(64, 512);
			hs   = rand_range(0, 2) ? rand_range(64, 512) : 0;
			vs   = rand_range(0, 2) ? rand_range(64, 512) : 0;
			ax   = rand_range(1, 7);
			ay   = rand_range(1, 7);
			fs   = (mode == 1);
			if (mode == 2) begin
				ax = 13'h1000 | rand_range(1, 4095);
				if (rand_range(0, 2) != 0) begin
					ay = 13'h1000 | rand_range(1, 4095);
				end
			end
			apply_window(w, h, hs, vs, fs, ax, ay);
		end
		finish_test("aspect modes");

		start_test();
		run_sync(1'b1, 1'b0, 3 * LINE_LEN * FRAME_LEN, 2 * LINE_LEN * FRAME_LEN);
		finish_test("active-low sync");

		start_test();
		run_sync(1'b0, 1'b0, 3 * LINE_LEN * FRAME_LEN, 2 * LINE_LEN * FRAME_LEN);
		finish_test("active-high sync");

		start_test();
		run_sync(1'b1, 1'b1, 3 * LINE_LEN * FRAME_LEN, 2 * LINE_LEN * FRAME_LEN);
		finish_test("composite sync");

		errors = errors + u_video_helper_top.u_video_helper_assert.fail_count;
		$display("Tests run %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* testbench/video_helper_assert.sv */
/*
 * Concurrent checks on the video helper, bound into the top level.
 * Covers the Wishbone ack handshake and the ordering of the window edges.
 */
`timescale 1ns/10ps

module video_helper_assert (
	input logic               clk_sys,
	input logic               resetd,
	input logic               i_wb_cyc,
	input logic               i_wb_stb,
	input logic               o_wb_ack,
	input video_pkg::coord_t  width,
	input video_pkg::coord_t  o_hmin,
	input video_pkg::coord_t  o_hmax
);

	int fail_count = 0;

	// Ack answers a request seen on the cycle before
	ack_needs_request: assert property (@(posedge clk_sys) disable iff (resetd)
		$rose(o_wb_ack) |-> $past(i_wb_cyc && i_wb_stb))
		else begin
			$error("o_wb_ack rose without cyc and stb");
			fail_count++;
		end

	ack_one_cycle: assert property (@(posedge clk_sys) disable iff (resetd)
		o_wb_ack |=> !o_wb_ack)
		else begin
			$error("o_wb_ack held for more than one cycle");
			fail_count++;
		end

	window_ordered: assert property (@(posedge clk_sys) disable iff (resetd)
		(width != '0) |-> (o_hmin <= o_hmax))
		else begin
			$error("hmin above hmax");
			fail_count++;
		end

endmodule

bind video_helper_top video_helper_assert u_video_helper_assert (
	.clk_sys  (clk_sys),
	.resetd   (resetd),
	.i_wb_cyc (i_wb_cyc),
	.i_wb_stb (i_wb_stb),
	.o_wb_ack (o_wb_ack),
	.width    (width),
	.o_hmin   (o_hmin),
	.o_hmax   (o_hmax)
);

/* hw/video_helper_top.sv */
/*
 * Video output helper. Configured over Wishbone classic, it drives the
 * centred scaler window and cleans up the incoming syncs.
 */
`timescale 1ns/10ps

module video_helper_top (
	input  logic                  clk_sys,
	input  logic                  resetd,

	input  logic                  i_wb_cyc,
	input  logic                  i_wb_stb,
	input  logic                  i_wb_we,
	input  video_pkg::reg_addr_t  i_wb_adr,
	input  video_pkg::bus_data_t  i_wb_dat,
	output video_pkg::bus_data_t  o_wb_dat,
	output logic                  o_wb_ack,

	input  logic                  i_hs_raw,
	input  logic                  i_vs_raw,

	output video_pkg::coord_t     o_hmin,
	output video_pkg::coord_t     o_hmax,
	output video_pkg::coord_t     o_vmin,
	output video_pkg::coord_t     o_vmax,
	output logic                  o_hs,
	output logic                  o_vs,
	output logic                  o_csync
);

	video_pkg::coord_t  width, height, hset, vset;
	video_pkg::aspect_t arx, ary;
	logic               freescale;

	video_cfg_regs u_video_cfg_regs (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_wb_cyc    (i_wb_cyc),
		.i_wb_stb    (i_wb_stb),
		.i_wb_we     (i_wb_we),
		.i_wb_adr    (i_wb_adr),
		.i_wb_dat    (i_wb_dat),
		.o_wb_dat    (o_wb_dat),
		.o_wb_ack    (o_wb_ack),
		.o_width     (width),
		.o_height    (height),
		.o_hset      (hset),
		.o_vset      (vset),
		.o_freescale (freescale),
		.o_arx       (arx),
		.o_ary       (ary)
	);

	window_calc u_window_calc (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_width     (width),
		.i_height    (height),
		.i_hset      (hset),
		.i_vset      (vset),
		.i_freescale (freescale),
		.i_arx       (arx),
		.i_ary       (ary),
		.o_hmin      (o_hmin),
		.o_hmax      (o_hmax),
		.o_vmin      (o_vmin),
		.o_vmax      (o_vmax)
	);

	////////////////////////////////////////
	// Sync path
	////////////////////////////////////////

	sync_polarity u_sync_h (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_hs_raw),
		.o_sync  (o_hs)
	);

	sync_polarity u_sync_v (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vs_raw),
		.o_sync  (o_vs)
	);

	csync_gen u_csync_gen (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_hsync (o_hs),
		.i_vsync (o_vs),
		.o_csync (o_csync)
	);

endmodule

/* hw/csync_gen.sv */
/*
 * Composite sync from active-high hsync and vsync.
 * During vsync the hsync pulse is shifted by one pulse width and inverted,
 * giving the serrated vertical interval.
 */
`timescale 1ns/10ps
`include "video_consts.svh"

module csync_gen (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_hsync,
	input  logic i_vsync,
	output logic o_csync
);

	localparam int CW = `VID_CSYNC_CNT_BITS;

	logic          prev_hs, cs_hs, cs_vs;
	logic [CW-1:0] h_cnt, line_len, hs_len;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			prev_hs  <= 1'b0;
			cs_hs    <= 1'b0;
			cs_vs    <= 1'b0;
			h_cnt    <= '0;
			line_len <= '0;
			hs_len   <= '0;
		end else begin
			// Line and pulse lengths
			h_cnt   <= h_cnt + 1'b1;
			prev_hs <= i_hsync;
			if (prev_hs != i_hsync) begin
				h_cnt <= '0;
				if (i_hsync) begin
					line_len <= h_cnt - hs_len;
					cs_hs    <= 1'b0;
				end else begin
					hs_len <= h_cnt;
				end
			end
			if (!i_vsync) begin
				cs_hs <= i_hsync;
			end else if (h_cnt == line_len) begin
				cs_hs <= 1'b1;
			end
			cs_vs <= i_vsync;
		end
	end

	assign o_csync = cs_vs ^ cs_hs;

endmodule

/* hw/sync_polarity.sv */
/*
 * Makes a sync of unknown polarity active high.
 * Compares the high and low phase lengths; the shorter one is the pulse.
 */
`timescale 1ns/10ps

module sync_polarity (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	localparam int CNT_BITS = 16;

	logic                s1, s2, pol;
	logic [CNT_BITS-1:0] cnt, hi_len, lo_len;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1     <= 1'b0;
			s2     <= 1'b0;
			cnt    <= '0;
			hi_len <= '0;
			lo_len <= '0;
			pol    <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;
			if (s1 && !s2) begin
				lo_len <= cnt;
			end
			if (!s1 && s2) begin
				hi_len <= cnt;
			end
			// Saturates on a stuck input
			if (s1 != s2) begin
				cnt <= '0;
			end else if (!(&cnt)) begin
				cnt <= cnt + 1'b1;
			end
			pol <= (hi_len > lo_len);
		end
	end

	assign o_sync = s2 ^ pol;

endmodule

/* hw/window_calc.sv */
/*
 * Centred output window from the mode size, the size limits and the aspect.
 * Runs in a loop and restarts as soon as any input changes, so the window
 * follows a register write after at most one pass plus one division.
 */
`timescale 1ns/10ps

module window_calc (
	input  logic                clk_sys,
	input  logic                resetd,
	input  video_pkg::coord_t   i_width,
	input  video_pkg::coord_t   i_height,
	input  video_pkg::coord_t   i_hset,
	input  video_pkg::coord_t   i_vset,
	input  logic                i_freescale,
	input  video_pkg::aspect_t  i_arx,
	input  video_pkg::aspect_t  i_ary,
	output video_pkg::coord_t   o_hmin,
	output video_pkg::coord_t   o_hmax,
	output video_pkg::coord_t   o_vmin,
	output video_pkg::coord_t   o_vmax
);

	localparam int CW      = $bits(video_pkg::coord_t);
	localparam int ABS_BIT = $bits(video_pkg::aspect_t) - 1;
	localparam int CFG_W   = 4 * CW + 1 + 2 * (ABS_BIT + 1);

	typedef enum logic [2:0] {S_DECIDE, S_START_W, S_WAIT_W, S_WAIT_H, S_OUT} state_t;

	state_t             state;
	logic [CFG_W-1:0]   cfg_live;
	logic [CFG_W-1:0]   cfg_snap;
	logic               cfg_same;
	video_pkg::coord_t  w_lim, h_lim, arx_sz, ary_sz;
	video_pkg::coord_t  wcalc, hcalc, videow, videoh, hmin_n, vmin_n;
	logic               md_start, md_busy;
	video_pkg::coord_t  md_mul1, md_mul2, md_div, md_result;

	umuldiv u_umuldiv (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_result)
	);

	always_comb begin
		cfg_live = {i_width, i_height, i_hset, i_vset, i_freescale, i_arx, i_ary};
		cfg_same = (cfg_live == cfg_snap);
		w_lim    = (i_hset != '0 && i_hset < i_width) ? i_hset : i_width;
		h_lim    = (i_vset != '0 && i_vset < i_height) ? i_vset : i_height;
		arx_sz   = i_arx[CW-1:0];
		ary_sz   = i_ary[CW-1:0];
		// Never larger than the limited size
		videow   = (wcalc > w_lim) ? w_lim : wcalc;
		videoh   = (hcalc > h_lim) ? h_lim : hcalc;
		hmin_n   = (i_width - videow) >> 1;
		vmin_n   = (i_height - videoh) >> 1;
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state    <= S_DECIDE;
			md_start <= 1'b0;
			o_hmin   <= '0;
			o_hmax   <= '0;
			o_vmin   <= '0;
			o_vmax   <= '0;
		end else begin
			md_start <= 1'b0;
			case (state)
				S_DECIDE: begin
					cfg_snap <= cfg_live;
					if (i_freescale || i_arx == '0 || i_ary == '0) begin
						wcalc <= w_lim;
						hcalc <= h_lim;
						state <= S_OUT;
					end else if (i_arx[ABS_BIT] || i_ary[ABS_BIT]) begin
						wcalc <= arx_sz;
						hcalc <= ary_sz;
						state <= S_OUT;
					end else begin
						state <= S_START_W;
					end
				end
				// Divider may still be finishing an abandoned pass
				S_START_W: if (!md_busy && cfg_same) begin
					md_mul1  <= h_lim;
					md_mul2  <= arx_sz;
					md_div   <= ary_sz;
					md_start <= 1'b1;
					state    <= S_WAIT_W;
				end
				S_WAIT_W: if (!md_start && !md_busy) begin
					wcalc    <= md_result;
					md_mul1  <= w_lim;
					md_mul2  <= ary_sz;
					md_div   <= arx_sz;
					md_start <= cfg_same;
					state    <= S_WAIT_H;
				end
				S_WAIT_H: if (!md_start && !md_busy) begin
					hcalc <= md_result;
					state <= S_OUT;
				end
				default: begin
					if (cfg_same) begin
						o_hmin <= hmin_n;
						o_hmax <= hmin_n + videow - 1'b1;
						o_vmin <= vmin_n;
						o_vmax <= vmin_n + videoh - 1'b1;
					end
					state <= S_DECIDE;
				end
			endcase
			// Any input change abandons the pass
			if (!cfg_same) begin
				cfg_snap <= cfg_live;
				state    <= S_DECIDE;
			end
		end
	end

endmodule

/* hw/umuldiv.sv */
/*
 * Unsigned (a * b) / c on coordinate-sized operands.
 * One start pulse loads the product, then a restoring divider runs one
 * quotient bit per clock. The result is valid once busy drops.
 */
`timescale 1ns/10ps
`include "video_consts.svh"

module umuldiv (
	input  logic               clk_sys,
	input  logic               resetd,
	input  logic               i_start,
	input  video_pkg::coord_t  i_mul1,
	input  video_pkg::coord_t  i_mul2,
	input  video_pkg::coord_t  i_div,
	output logic               o_busy,
	output video_pkg::coord_t  o_result
);

	localparam int CW    = $bits(video_pkg::coord_t);
	localparam int QW    = 2 * CW;
	localparam int STEPS = `VID_DIV_STEPS;

	logic [QW-1:0]             quo;
	video_pkg::coord_t         rem;
	video_pkg::coord_t         div_r;
	logic [$clog2(STEPS)-1:0]  step;
	logic [CW:0]               trial;
	logic                      fits;

	// Partial remainder with the next dividend bit shifted in
	always_comb begin
		trial = {rem, quo[QW-1]};
		fits  = (trial >= {1'b0, div_r});
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy <= 1'b0;
			step   <= '0;
		end else if (!o_busy) begin
			if (i_start) begin
				o_busy <= 1'b1;
				step   <= '0;
			end
		end else begin
			step <= step + 1'b1;
			if (step == STEPS - 1) begin
				o_busy <= 1'b0;
			end
		end
	end

	// Dividend bits leave at the top while quotient bits enter at the bottom
	always_ff @(posedge clk_sys) begin
		if (!o_busy && i_start) begin
			quo   <= i_mul1 * i_mul2;
			rem   <= '0;
			div_r <= i_div;
		end else if (o_busy) begin
			rem <= fits ? CW'(trial - {1'b0, div_r}) : trial[CW-1:0];
			quo <= {quo[QW-2:0], fits};
		end
	end

	assign o_result = quo[CW-1:0];

endmodule

/* hw/video_cfg_regs.sv */
/*
 * Configuration registers of the video helper on a Wishbone classic slave.
 * Holds the mode size, the size limits, freescale and the aspect pair.
 * Every access is acked one cycle after cyc and stb, with no wait states.
 */
`timescale 1ns/10ps
`include "video_consts.svh"

module video_cfg_regs (
	input  logic                  clk_sys,
	input  logic                  resetd,

	input  logic                  i_wb_cyc,
	input  logic                  i_wb_stb,
	input  logic                  i_wb_we,
	input  video_pkg::reg_addr_t  i_wb_adr,
	input  video_pkg::bus_data_t  i_wb_dat,
	output video_pkg::bus_data_t  o_wb_dat,
	output logic                  o_wb_ack,

	output video_pkg::coord_t     o_width,
	output video_pkg::coord_t     o_height,
	output video_pkg::coord_t     o_hset,
	output video_pkg::coord_t     o_vset,
	output logic                  o_freescale,
	output video_pkg::aspect_t    o_arx,
	output video_pkg::aspect_t    o_ary
);

	logic access;

	// New cycle seen, ack not yet given
	assign access = i_wb_cyc && i_wb_stb && !o_wb_ack;

	////////////////////////////////////////
	// Write side
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_wb_ack    <= 1'b0;
			o_width     <= `VID_RST_WIDTH;
			o_height    <= `VID_RST_HEIGHT;
			o_hset      <= '0;
			o_vset      <= '0;
			o_freescale <= 1'b0;
			o_arx       <= '0;
			o_ary       <= '0;
		end else begin
			o_wb_ack <= access;
			if (access && i_wb_we) begin
				case (i_wb_adr)
					`VID_ADDR_WIDTH:     o_width     <= i_wb_dat[`VID_COORD_BITS-1:0];
					`VID_ADDR_HEIGHT:    o_height    <= i_wb_dat[`VID_COORD_BITS-1:0];
					`VID_ADDR_HSET:      o_hset      <= i_wb_dat[`VID_COORD_BITS-1:0];
					`VID_ADDR_VSET:      o_vset      <= i_wb_dat[`VID_COORD_BITS-1:0];
					`VID_ADDR_FREESCALE: o_freescale <= i_wb_dat[0];
					`VID_ADDR_ARX:       o_arx       <= i_wb_dat[`VID_ASPECT_BITS-1:0];
					`VID_ADDR_ARY:       o_ary       <= i_wb_dat[`VID_ASPECT_BITS-1:0];
					default: ;
				endcase
			end
		end
	end

	////////////////////////////////////////
	// Readback
	////////////////////////////////////////

	// Unused bits and unmapped words read as zero
	always_ff @(posedge clk_sys) begin
		if (access) begin
			case (i_wb_adr)
				`VID_ADDR_WIDTH:     o_wb_dat <= video_pkg::bus_data_t'(o_width);
				`VID_ADDR_HEIGHT:    o_wb_dat <= video_pkg::bus_data_t'(o_height);
				`VID_ADDR_HSET:      o_wb_dat <= video_pkg::bus_data_t'(o_hset);
				`VID_ADDR_VSET:      o_wb_dat <= video_pkg::bus_data_t'(o_vset);
				`VID_ADDR_FREESCALE: o_wb_dat <= video_pkg::bus_data_t'(o_freescale);
				`VID_ADDR_ARX:       o_wb_dat <= video_pkg::bus_data_t'(o_arx);
				`VID_ADDR_ARY:       o_wb_dat <= video_pkg::bus_data_t'(o_ary);
				default:             o_wb_dat <= '0;
			endcase
		end
	end

endmodule

/* hw/video_pkg.sv */
/*
 * Shared types of the video helper.
 * RTL and testbench refer to them by scoped names.
 */
`include "video_consts.svh"

package video_pkg;

	////////////////////////////////////////
	// Geometry
	////////////////////////////////////////

	// Pixel or line count
	typedef logic [`VID_COORD_BITS-1:0] coord_t;

	// Aspect component, top bit set means an absolute size in the low bits
	typedef logic [`VID_ASPECT_BITS-1:0] aspect_t;

	////////////////////////////////////////
	// Wishbone
	////////////////////////////////////////

	// Word address
	typedef logic [`VID_ADDR_BITS-1:0] reg_addr_t;

	// Read and write data
	typedef logic [`VID_DATA_BITS-1:0] bus_data_t;

endpackage

/* hw/video_consts.svh */
/*
 * Register map, field widths and fixed counts of the video helper.
 * Included by the package, by the RTL that needs an address or a count,
 * and by the testbench.
 */
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// Wishbone word addresses
`define VID_ADDR_WIDTH      4'd0
`define VID_ADDR_HEIGHT     4'd1
`define VID_ADDR_HSET       4'd2
`define VID_ADDR_VSET       4'd3
`define VID_ADDR_FREESCALE  4'd4
`define VID_ADDR_ARX        4'd5
`define VID_ADDR_ARY        4'd6

// Field widths
`define VID_COORD_BITS      12
`define VID_ASPECT_BITS     13
`define VID_ADDR_BITS       4
`define VID_DATA_BITS       16

// Mode size after reset, 1080p
`define VID_RST_WIDTH       12'd1920
`define VID_RST_HEIGHT      12'd1080

// One quotient bit per step
`define VID_DIV_STEPS       24
`define VID_CSYNC_CNT_BITS  16

`endif
